// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = exe_stage_tb
FILELIST = build.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove build output"
	@echo "  help   list the targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// File: build.f
+incdir+logic
+incdir+sim
logic/pipeline_types.sv
logic/exe_types.sv
logic/regular_alu.sv
logic/div_unit.sv
logic/wb_arbiter.sv
logic/exe_stage.sv
sim/exe_stage_tb.sv

// File: logic/alu_consts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// Logic group
`define ALU_OR          8'h01
`define ALU_ORI         8'h02
`define ALU_LU12I       8'h03
`define ALU_NOR         8'h04
`define ALU_AND         8'h05
`define ALU_ANDI        8'h06
`define ALU_XOR         8'h07
`define ALU_XORI        8'h08

// Shift group
`define ALU_SLLW        8'h10
`define ALU_SLLIW       8'h11
`define ALU_SRLW        8'h12
`define ALU_SRLIW       8'h13
`define ALU_SRAW        8'h14
`define ALU_SRAIW       8'h15

// Arithmetic group
`define ALU_ADDW        8'h20
`define ALU_SUBW        8'h21
`define ALU_ADDIW       8'h22
`define ALU_PCADDU12I   8'h23
`define ALU_SLT         8'h24
`define ALU_SLTU        8'h25
`define ALU_SLTI        8'h26
`define ALU_SLTUI       8'h27
`define ALU_MULW        8'h28
`define ALU_MULHW       8'h29
`define ALU_MULHWU      8'h2a

// Divider group
`define ALU_DIVW        8'h30
`define ALU_MODW        8'h31
`define ALU_DIVWU       8'h32
`define ALU_MODWU       8'h33

`define ALU_SEL_LOGIC       3'b001
`define ALU_SEL_SHIFT       3'b010
`define ALU_SEL_ARITHMETIC  3'b011
`define ALU_SEL_DIV         3'b100

`define DIV_STEPS       32

`endif

// File: logic/div_unit.sv
`timescale 1ns/1ps
`include "alu_consts.svh"

module div_unit (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   issue_valid,
    input  pipeline_types::issue_t issue,
    output logic                   div_claim,
    output logic                   div_busy,
    output logic                   div_done,
    output exe_types::wb_t         div_wb
);
    import pipeline_types::*;
    import exe_types::*;

    localparam int STEP_W = $clog2(`DIV_STEPS);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`DIV_STEPS - 1);

    div_state_t        state;
    logic [STEP_W-1:0] step_cnt;

    logic   start;
    logic   op_signed;
    logic   dividend_neg;
    logic   divisor_neg;
    bus32_t dividend_mag;
    bus32_t divisor_mag;

    bus32_t   quo_q;
    bus32_t   rem_q;
    bus32_t   divisor_q;
    logic     quo_neg;
    logic     rem_neg;
    logic     want_mod;
    logic     by_zero;
    reg_tag_t tag_q;

    logic [32:0] trial;
    logic [32:0] diff;
    bus32_t      quo_fix;
    bus32_t      rem_fix;

    assign div_claim = issue.alusel == `ALU_SEL_DIV;
    assign start     = issue_valid && div_claim && (state == IDLE);

    assign op_signed    = (issue.aluop == `ALU_DIVW) || (issue.aluop == `ALU_MODW);
    assign dividend_neg = op_signed && issue.reg1[31];
    assign divisor_neg  = op_signed && issue.reg2[31];
    assign dividend_mag = dividend_neg ? -issue.reg1 : issue.reg1;
    assign divisor_mag  = divisor_neg ? -issue.reg2 : issue.reg2;

    // Next dividend bit shifted into the partial remainder
    assign trial = {rem_q, quo_q[31]};
    assign diff  = trial - {1'b0, divisor_q};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state    <= RUN;
                        step_cnt <= '0;
                    end
                end
                RUN: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == LAST_STEP) begin
                        state <= FIN;
                    end
                end
                default: state <= IDLE;  // FIN lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo_q     <= dividend_mag;
            rem_q     <= '0;
            divisor_q <= divisor_mag;
            quo_neg   <= dividend_neg ^ divisor_neg;
            rem_neg   <= dividend_neg;
            want_mod  <= (issue.aluop == `ALU_MODW) || (issue.aluop == `ALU_MODWU);
            by_zero   <= issue.reg2 == '0;
            tag_q     <= issue.tag;
        end else if (state == RUN) begin
            if (!diff[32]) begin
                rem_q <= diff[31:0];
                quo_q <= {quo_q[30:0], 1'b1};
            end else begin
                rem_q <= trial[31:0];
                quo_q <= {quo_q[30:0], 1'b0};
            end
        end
    end

    // Zero divisor keeps the all-ones quotient
    assign quo_fix = (quo_neg && !by_zero) ? -quo_q : quo_q;
    assign rem_fix = rem_neg ? -rem_q : rem_q;

    assign div_busy = state != IDLE;
    assign div_done = state == FIN;
    assign div_wb   = '{tag: tag_q, data: want_mod ? rem_fix : quo_fix};

endmodule

// File: logic/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   issue_valid,
    input  pipeline_types::issue_t issue,
    output logic                   wb_valid,
    output exe_types::wb_t         wb,
    output logic                   div_busy,
    output logic                   alu_full
);
    import pipeline_types::*;
    import exe_types::*;

    bus32_t alu_result;
    wb_t    alu_wb;
    wb_t    div_wb;
    logic   div_claim;
    logic   div_done;
    logic   capture;

    regular_alu alu_i (
        .aluop  (issue.aluop),
        .alusel (issue.alusel),
        .reg1   (issue.reg1),
        .reg2   (issue.reg2),
        .result (alu_result)
    );

    div_unit div_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .div_claim   (div_claim),
        .div_busy    (div_busy),
        .div_done    (div_done),
        .div_wb      (div_wb)
    );

    assign capture = issue_valid && !div_claim;  // Non-divide issues go to the buffer
    assign alu_wb  = '{tag: issue.tag, data: alu_result};

    wb_arbiter arb_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .capture  (capture),
        .alu_wb   (alu_wb),
        .div_done (div_done),
        .div_wb   (div_wb),
        .wb_valid (wb_valid),
        .wb       (wb),
        .alu_full (alu_full)
    );

endmodule

// File: logic/exe_types.sv
package exe_types;

    import pipeline_types::*;

    typedef struct packed {
        reg_tag_t tag;
        bus32_t   data;
    } wb_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIN
    } div_state_t;

endpackage

// File: logic/pipeline_types.sv
package pipeline_types;

    typedef logic [31:0] bus32_t;
    typedef logic [63:0] bus64_t;

    typedef logic [7:0] alu_op_t;
    typedef logic [2:0] alu_sel_t;

    // Destination register number, used as the result tag
    typedef logic [4:0] reg_tag_t;

    typedef struct packed {
        alu_op_t  aluop;
        alu_sel_t alusel;
        bus32_t   reg1;
        bus32_t   reg2;
        reg_tag_t tag;
    } issue_t;

endpackage

// File: logic/regular_alu.sv
`timescale 1ns/1ps
`include "alu_consts.svh"

module regular_alu (
    input  pipeline_types::alu_op_t  aluop,
    input  pipeline_types::alu_sel_t alusel,
    input  pipeline_types::bus32_t   reg1,
    input  pipeline_types::bus32_t   reg2,
    output pipeline_types::bus32_t   result
);
    import pipeline_types::*;

    bus32_t logic_res;
    bus32_t shift_res;
    bus32_t arith_res;

    logic   do_sub;
    bus32_t addend;
    bus32_t sum;
    logic   lt_signed;
    logic   lt_unsigned;
    logic   cmp_signed;

    logic   mul_signed;
    bus32_t mul_a;
    bus32_t mul_b;
    bus64_t mul_mag;
    bus64_t mul_res;

    always_comb begin
        case (aluop)
            `ALU_OR, `ALU_ORI, `ALU_LU12I: logic_res = reg1 | reg2;
            `ALU_NOR:                      logic_res = ~(reg1 | reg2);
            `ALU_AND, `ALU_ANDI:           logic_res = reg1 & reg2;
            `ALU_XOR, `ALU_XORI:           logic_res = reg1 ^ reg2;
            default:                       logic_res = '0;
        endcase
    end

    always_comb begin
        case (aluop)
            `ALU_SLLW, `ALU_SLLIW: shift_res = reg1 << reg2[4:0];
            `ALU_SRLW, `ALU_SRLIW: shift_res = reg1 >> reg2[4:0];
            `ALU_SRAW, `ALU_SRAIW: shift_res = $signed(reg1) >>> reg2[4:0];
            default:               shift_res = '0;
        endcase
    end

    assign do_sub = (aluop == `ALU_SUBW) || (aluop == `ALU_SLT) || (aluop == `ALU_SLTI);
    assign addend = do_sub ? (~reg2 + 32'd1) : reg2;
    assign sum    = reg1 + addend;

    // Sign of the difference decides when the operand signs agree
    assign lt_signed   = (reg1[31] && !reg2[31]) || ((reg1[31] == reg2[31]) && sum[31]);
    assign lt_unsigned = reg1 < reg2;
    assign cmp_signed  = (aluop == `ALU_SLT) || (aluop == `ALU_SLTI);

    // Multiply on magnitudes, sign restored afterwards
    assign mul_signed = (aluop == `ALU_MULW) || (aluop == `ALU_MULHW);
    assign mul_a      = (mul_signed && reg1[31]) ? (~reg1 + 32'd1) : reg1;
    assign mul_b      = (mul_signed && reg2[31]) ? (~reg2 + 32'd1) : reg2;
    assign mul_mag    = mul_a * mul_b;
    assign mul_res    = (mul_signed && (reg1[31] ^ reg2[31])) ? (~mul_mag + 64'd1) : mul_mag;

    always_comb begin
        case (aluop)
            `ALU_ADDW, `ALU_SUBW, `ALU_ADDIW, `ALU_PCADDU12I: begin
                arith_res = sum;
            end
            `ALU_SLT, `ALU_SLTU, `ALU_SLTI, `ALU_SLTUI: begin
                arith_res = {31'b0, cmp_signed ? lt_signed : lt_unsigned};
            end
            `ALU_MULW: begin
                arith_res = mul_res[31:0];
            end
            `ALU_MULHW, `ALU_MULHWU: begin
                arith_res = mul_res[63:32];
            end
            default: begin
                arith_res = '0;
            end
        endcase
    end

    always_comb begin
        case (alusel)
            `ALU_SEL_LOGIC:      result = logic_res;
            `ALU_SEL_SHIFT:      result = shift_res;
            `ALU_SEL_ARITHMETIC: result = arith_res;
            default:             result = '0;  // Divider ops land here
        endcase
    end

endmodule

// File: logic/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           capture,
    input  exe_types::wb_t alu_wb,
    input  logic           div_done,
    input  exe_types::wb_t div_wb,
    output logic           wb_valid,
    output exe_types::wb_t wb,
    output logic           alu_full
);
    import exe_types::*;

    wb_t        fifo_mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;

    logic bypass;
    logic push;
    logic pop;

    // Divider owns the port whenever it finishes
    assign pop      = !div_done && (count != 2'd0);
    assign bypass   = capture && !div_done && (count == 2'd0);
    assign push     = capture && !bypass;
    assign alu_full = count == 2'd2;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
            count    <= 2'd0;
            wb_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count    <= count + {1'b0, push} - {1'b0, pop};
            wb_valid <= div_done || pop || bypass;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= alu_wb;
        end
        if (div_done) begin
            wb <= div_wb;
        end else if (pop) begin
            wb <= fifo_mem[rd_ptr];  // Oldest entry first
        end else if (bypass) begin
            wb <= alu_wb;
        end
    end

endmodule

// File: sim/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

`include "alu_consts.svh"

function automatic bus32_t lcg_step(input bus32_t s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// Unit follows the high nibble of the op code
function automatic alu_sel_t unit_of(input alu_op_t op);
    case (op[7:4])
        4'h0:    return `ALU_SEL_LOGIC;
        4'h1:    return `ALU_SEL_SHIFT;
        4'h2:    return `ALU_SEL_ARITHMETIC;
        4'h3:    return `ALU_SEL_DIV;
        default: return 3'b000;
    endcase
endfunction

function automatic bus32_t expected_result(input alu_op_t op, input bus32_t a, input bus32_t b);
    logic signed [63:0] sprod;
    logic        [63:0] uprod;
    logic               ovf;
    logic signed [31:0] squo;
    logic signed [31:0] srem;
    sprod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    uprod = {32'b0, a} * {32'b0, b};
    ovf   = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    squo  = '0;
    srem  = '0;
    if (b != '0 && !ovf) begin
        squo = $signed(a) / $signed(b);
        srem = $signed(a) % $signed(b);
    end
    case (op)
        `ALU_OR, `ALU_ORI, `ALU_LU12I:             return a | b;
        `ALU_NOR:                                  return ~(a | b);
        `ALU_AND, `ALU_ANDI:                       return a & b;
        `ALU_XOR, `ALU_XORI:                       return a ^ b;
        `ALU_SLLW, `ALU_SLLIW:                     return a << b[4:0];
        `ALU_SRLW, `ALU_SRLIW:                     return a >> b[4:0];
        `ALU_SRAW, `ALU_SRAIW:                     return $signed(a) >>> b[4:0];
        `ALU_ADDW, `ALU_ADDIW, `ALU_PCADDU12I:     return a + b;
        `ALU_SUBW:                                 return a - b;
        `ALU_SLT, `ALU_SLTI:                       return {31'b0, $signed(a) < $signed(b)};
        `ALU_SLTU, `ALU_SLTUI:                     return {31'b0, a < b};
        `ALU_MULW:                                 return sprod[31:0];
        `ALU_MULHW:                                return sprod[63:32];
        `ALU_MULHWU:                               return uprod[63:32];
        `ALU_DIVW:  return (b == '0) ? '1 : (ovf ? 32'h8000_0000 : squo);
        `ALU_MODW:  return (b == '0) ? a : (ovf ? 32'h0 : srem);
        `ALU_DIVWU: return (b == '0) ? '1 : a / b;
        `ALU_MODWU: return (b == '0) ? a : a % b;
        default:    return '0;
    endcase
endfunction

`endif

// File: sim/exe_stage_tb.sv
`timescale 1ns/1ps

module exe_stage_tb;
    import pipeline_types::*;
    import exe_types::*;

    `include "tb_ref_model.svh"

    localparam int TIMEOUT = 100;
    localparam alu_op_t ALU_OPS [25] = '{
        `ALU_OR, `ALU_ORI, `ALU_LU12I, `ALU_NOR, `ALU_AND, `ALU_ANDI, `ALU_XOR, `ALU_XORI,
        `ALU_SLLW, `ALU_SLLIW, `ALU_SRLW, `ALU_SRLIW, `ALU_SRAW, `ALU_SRAIW,
        `ALU_ADDW, `ALU_SUBW, `ALU_ADDIW, `ALU_PCADDU12I, `ALU_SLT, `ALU_SLTU,
        `ALU_SLTI, `ALU_SLTUI, `ALU_MULW, `ALU_MULHW, `ALU_MULHWU};
    localparam alu_op_t DIV_OPS [4] = '{`ALU_DIVW, `ALU_MODW, `ALU_DIVWU, `ALU_MODWU};
    localparam bus32_t CORNERS [6] = '{32'h0, 32'hffff_ffff, 32'h8000_0000,
                                       32'h0000_001f, 32'h1, 32'h7fff_ffff};

    logic     clk;
    logic     arst_n;
    logic     issue_valid;
    issue_t   issue;
    logic     wb_valid;
    wb_t      wb;
    logic     div_busy;
    logic     alu_full;

    bus32_t   exp_data [32];
    logic     pending [32];
    logic     is_div [32];
    reg_tag_t alu_order [$];
    logic     div_live;
    reg_tag_t div_tag;
    logic     lat_check;  // Issue made with the stage idle
    reg_tag_t lat_tag;
    reg_tag_t tag_ctr;
    bus32_t   seed;
    bus32_t   a;
    bus32_t   b;
    int       mismatches;
    int       errors;

    exe_stage dut_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .div_busy    (div_busy),
        .alu_full    (alu_full)
    );

    always #4 clk = ~clk;

    function automatic bus32_t next_rand();
        seed = lcg_step(seed);
        return seed;
    endfunction

    function automatic int count_pending(input logic alu_only);
        int n;
        n = 0;
        for (int t = 0; t < 32; t++) begin
            if (pending[t] && !(alu_only && is_div[t])) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic abort_run(input string why);
        errors++;
        $display("%s", why);
        $display("error counts: %0d mismatches, %0d other", mismatches, errors);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic issue_op(input alu_op_t op, input bus32_t x, input bus32_t y, input logic idle);
        int       guard;
        logic     ready;
        logic     for_div;
        reg_tag_t tag;
        guard   = 0;
        ready   = 1'b0;
        for_div = unit_of(op) == `ALU_SEL_DIV;
        while (!ready) begin
            @(negedge clk);
            ready = !alu_full && !(for_div && div_busy);
            if (!ready) begin
                issue_valid = 1'b0;
                lat_check   = 1'b0;
                guard++;
                if (guard >= TIMEOUT) abort_run("timeout waiting for room to issue");
            end
        end
        tag = tag_ctr;
        for (int s = 0; s < 32 && pending[tag]; s++) begin
            tag = tag + 1'b1;  // Skip tags still in flight
        end
        tag_ctr     = tag + 1'b1;
        issue_valid = 1'b1;
        issue       = '{aluop: op, alusel: unit_of(op), reg1: x, reg2: y, tag: tag};
        lat_check   = idle;
        if (idle) lat_tag = tag;
        @(posedge clk);
        exp_data[tag] = expected_result(op, x, y);
        is_div[tag]   = for_div;
        pending[tag]  = 1'b1;
        if (for_div) begin
            div_live = 1'b1;
            div_tag  = tag;
        end else begin
            alu_order.push_back(tag);
        end
    endtask

    task automatic wait_all_done();
        int guard;
        guard = 0;
        @(negedge clk);
        issue_valid = 1'b0;
        lat_check   = 1'b0;
        @(posedge clk);
        while (count_pending(1'b0) != 0) begin
            @(posedge clk);
            guard++;
            if (guard >= TIMEOUT) abort_run("timeout waiting for outstanding results");
        end
    endtask

    task automatic check_writeback();
        assert (pending[wb.tag]) else begin
            errors++;
            $display("unexpected result on tag %0d at %0t", wb.tag, $time);
        end
        if (pending[wb.tag]) begin
            assert (wb.data == exp_data[wb.tag]) else begin
                mismatches++;
                $display("mismatch at %0t: wb.data tag %0d got %08h expected %08h",
                         $time, wb.tag, wb.data, exp_data[wb.tag]);
            end
            if (is_div[wb.tag]) begin
                div_live = 1'b0;
            end else begin
                assert (alu_order.size() > 0 && alu_order[0] == wb.tag) else begin
                    errors++;
                    $display("ALU tag %0d left out of program order at %0t", wb.tag, $time);
                end
                if (alu_order.size() > 0) void'(alu_order.pop_front());
            end
            pending[wb.tag] = 1'b0;
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (arst_n) begin
            if (alu_full) begin
                assert (count_pending(1'b1) >= 2) else begin
                    errors++;
                    $display("alu_full high at %0t with fewer than two ALU results held", $time);
                end
            end
            if (div_live && !(wb_valid && wb.tag == div_tag)) begin
                assert (div_busy) else begin
                    errors++;
                    $display("div_busy low at %0t while divide tag %0d runs", $time, div_tag);
                end
            end
            if (wb_valid) check_writeback();
        end
    end

    idle_latency: assert property (@(posedge clk) disable iff (!arst_n)
            lat_check |=> (wb_valid && wb.tag == lat_tag))
        else begin
            errors++;
            $display("tag %0d did not return one cycle after an idle issue", lat_tag);
        end

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        lat_check   = 1'b0;
        lat_tag     = '0;
        div_live    = 1'b0;
        div_tag     = '0;
        tag_ctr     = '0;
        seed        = 32'd7;
        mismatches  = 0;
        errors      = 0;
        for (int t = 0; t < 32; t++) begin
            pending[t]  = 1'b0;
            is_div[t]   = 1'b0;
            exp_data[t] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        assert (!wb_valid && !div_busy && !alu_full) else begin
            errors++;
            $display("outputs not idle after reset");
        end

        for (int i = 0; i < 25; i++) begin
            for (int n = 0; n < 4; n++) begin
                a = next_rand();
                b = next_rand();
                wait_all_done();
                issue_op(ALU_OPS[i], a, b, 1'b1);
            end
        end
        for (int i = 0; i < 25; i++) begin
            for (int j = 0; j < 6; j++) begin
                for (int k = 0; k < 6; k++) begin
                    issue_op(ALU_OPS[i], CORNERS[j], CORNERS[k], 1'b0);
                end
            end
        end
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 6; j++) begin
                for (int k = 0; k < 6; k++) begin
                    issue_op(DIV_OPS[i], CORNERS[j], CORNERS[k], 1'b0);
                end
            end
            for (int n = 0; n < 6; n++) begin
                a = next_rand();
                b = next_rand() >> 27;
                issue_op(DIV_OPS[i], a, b, 1'b0);
            end
        end

        // ALU stream across each divide's finish
        for (int r = 0; r < 4; r++) begin
            a = next_rand();
            b = next_rand() >> 20;
            issue_op(DIV_OPS[r], a, b, 1'b0);
            for (int n = 0; n < 40; n++) begin
                a = next_rand();
                b = next_rand();
                issue_op(ALU_OPS[n % 25], a, b, 1'b0);
            end
        end
        wait_all_done();

        $display("error counts: %0d mismatches, %0d other", mismatches, errors);
        if (mismatches == 0 && errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
